/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  //########################################
  // sizes
  //########################################

  localparam int WIDTH      = 16;
  localparam int NUMBYTE    = 2;
  localparam int NUMADDR    = 32;
  localparam int BITADDR    = 5;
  localparam int NUMVBNK    = 4;
  localparam int BITVBNK    = 2;
  localparam int NUMSROW    = 8;
  localparam int BITSROW    = 3;
  localparam int PHYWDTH    = 18;
  localparam int SRAM_DELAY = 1;

  localparam int BITBYTE = WIDTH / NUMBYTE;   // data bits per byte lane
  localparam int PHYBYTE = PHYWDTH / NUMBYTE; // byte lane plus its parity bit

  //########################################
  // types
  //########################################

  // low bits pick the bank so consecutive words land in different banks
  typedef struct packed {
    logic [BITSROW-1:0] row;
    logic [BITVBNK-1:0] bank;
  } mem_addr_fld_t;

  typedef union packed {
    logic [BITADDR-1:0] flat;
    mem_addr_fld_t      fld;
  } mem_addr_u;

  typedef struct packed {
    logic               read;
    logic               write;
    mem_addr_u          addr;
    logic [NUMBYTE-1:0] bw;
    logic [WIDTH-1:0]   din;
  } mem_cmd_t;

  // per lane the parity bit sits above its byte
  typedef struct packed {
    logic               write;
    logic               read;
    logic [BITSROW-1:0] row;
    logic [PHYWDTH-1:0] phy_din;
    logic [PHYWDTH-1:0] phy_bw;
  } bank_req_t;

  typedef struct packed {
    logic               vld;
    logic [BITVBNK-1:0] bank;
  } rd_tag_t;

  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] dout;
    logic             perr;
  } rd_rsp_t;

endpackage

`default_nettype wire

/* src/mem_init_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_init_fsm (
  input  logic clk,
  input  logic rst,
  input  logic last_row,
  output logic init_active,
  output logic count_en,
  output logic rw_ready
);

  typedef enum logic {
    CLEAR,
    SERVE
  } state_t;

  state_t state;

  // outputs are registered so nothing is strobed while reset is held
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= CLEAR;
      init_active <= 1'b0;
      rw_ready    <= 1'b0;
    end else begin
      case (state)
        CLEAR: begin
          if (last_row) begin
            state       <= SERVE;
            init_active <= 1'b0;
            rw_ready    <= 1'b1;
          end else begin
            init_active <= 1'b1; // first cycle out of reset arms the sweep
          end
        end
        SERVE: begin
          init_active <= 1'b0;
          rw_ready    <= 1'b1;  // stays here until the next reset
        end
        default: begin
          state       <= CLEAR;
          init_active <= 1'b0;
          rw_ready    <= 1'b0;
        end
      endcase
    end
  end

  assign count_en = init_active; // one row per cycle of the clear phase

endmodule

`default_nettype wire

/* src/row_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module row_counter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        count_en,
  output logic [mem_pkg::BITSROW-1:0] row_idx,
  output logic                        last_row
);
  import mem_pkg::*;

  logic [BITSROW-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (count_en) begin
      count <= count + 1'b1; // wraps back to row zero on its own
    end
  end

  assign row_idx  = count;
  assign last_row = count_en && (count == BITSROW'(NUMSROW - 1));

endmodule

`default_nettype wire

/* src/read_delay_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module read_delay_timer (
  input  logic             clk,
  input  logic             rst,
  input  mem_pkg::rd_tag_t tag_in,
  output mem_pkg::rd_tag_t tag_out
);
  import mem_pkg::*;

  // one stage per cycle of SRAM read latency
  rd_tag_t pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    pipe[0] <= tag_in;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      pipe[i] <= pipe[i-1];
    end
    if (rst) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        pipe[i].vld <= 1'b0; // bank field is only meaningful with vld
      end
    end
  end

  assign tag_out = pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

/* src/bank_router.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_router (
  input  logic                        clk,
  input  logic                        rst,
  input  mem_pkg::mem_cmd_t           cmd,
  input  logic                        init_active,
  input  logic [mem_pkg::BITSROW-1:0] row_idx,
  output mem_pkg::bank_req_t          bank_req [mem_pkg::NUMVBNK],
  output mem_pkg::rd_tag_t            rd_tag
);
  import mem_pkg::*;

  logic               cmd_en;
  logic               cmd_ok;
  logic               wr_go;
  logic               rd_go;
  logic [BITVBNK-1:0] bank;
  logic [BITSROW-1:0] row;
  logic [PHYWDTH-1:0] phy_din;
  logic [PHYWDTH-1:0] phy_bw;

  // set once the clear sweep has started, so commands stay blocked
  // from reset release until the sweep is over
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_en <= 1'b0;
    end else if (init_active) begin
      cmd_en <= 1'b1;
    end
  end

  assign cmd_ok = cmd_en && !init_active;
  assign wr_go  = cmd_ok && cmd.write;
  assign rd_go  = cmd_ok && cmd.read && !cmd.write; // write wins a collision

  assign bank = cmd.addr.fld.bank;
  assign row  = cmd.addr.fld.row;

  //########################################
  // byte lanes with even parity
  //########################################

  always_comb begin
    for (int b = 0; b < NUMBYTE; b++) begin
      phy_din[b*PHYBYTE +: PHYBYTE] = {^cmd.din[b*BITBYTE +: BITBYTE],
                                       cmd.din[b*BITBYTE +: BITBYTE]};
      phy_bw[b*PHYBYTE +: PHYBYTE]  = {PHYBYTE{cmd.bw[b]}};
    end
  end

  //########################################
  // per bank requests
  //########################################

  always_comb begin
    for (int i = 0; i < NUMVBNK; i++) begin
      bank_req[i] = '0;
      if (init_active) begin
        // all-zero data already carries correct even parity
        bank_req[i].write  = 1'b1;
        bank_req[i].row    = row_idx;
        bank_req[i].phy_bw = '1;
      end else if (bank == BITVBNK'(i)) begin
        bank_req[i].write   = wr_go;
        bank_req[i].read    = rd_go;
        bank_req[i].row     = row;
        bank_req[i].phy_din = phy_din;
        bank_req[i].phy_bw  = phy_bw;
      end
    end
  end

  assign rd_tag.vld  = rd_go;
  assign rd_tag.bank = bank;

endmodule

`default_nettype wire

/* src/sram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
  input  logic                        clk,
  input  mem_pkg::bank_req_t          req,
  output logic [mem_pkg::PHYWDTH-1:0] phy_dout
);
  import mem_pkg::*;

  logic [PHYWDTH-1:0] mem [NUMSROW];

  // bit-masked write, a read sees writes from earlier edges only
  always_ff @(posedge clk) begin
    if (req.write) begin
      mem[req.row] <= (mem[req.row] & ~req.phy_bw) | (req.phy_din & req.phy_bw);
    end
    if (req.read) begin
      phy_dout <= mem[req.row]; // held until the next read strobe
    end
  end

endmodule

`default_nettype wire

/* src/read_return.sv */
`timescale 1ns/1ps
`default_nettype none

module read_return (
  input  logic                        clk,
  input  logic                        rst,
  input  mem_pkg::rd_tag_t            tag,
  input  logic [mem_pkg::PHYWDTH-1:0] bank_dout [mem_pkg::NUMVBNK],
  output mem_pkg::rd_rsp_t            rsp
);
  import mem_pkg::*;

  logic [PHYWDTH-1:0] phy_sel;
  logic [WIDTH-1:0]   dout;
  logic [NUMBYTE-1:0] byte_err;

  assign phy_sel = bank_dout[tag.bank];

  // drop the parity bits and check each lane for odd weight
  always_comb begin
    for (int b = 0; b < NUMBYTE; b++) begin
      dout[b*BITBYTE +: BITBYTE] = phy_sel[b*PHYBYTE +: BITBYTE];
      byte_err[b]                = ^phy_sel[b*PHYBYTE +: PHYBYTE];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp.vld <= 1'b0;
    end else begin
      rsp.vld <= tag.vld;
    end
    rsp.dout <= dout;
    rsp.perr <= |byte_err;
  end

endmodule

`default_nettype wire

/* src/mem_1rw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_1rw_top (
  input  logic              clk,
  input  logic              rst,
  input  mem_pkg::mem_cmd_t cmd,
  output mem_pkg::rd_rsp_t  rsp,
  output logic              rw_ready
);
  import mem_pkg::*;

  logic               init_active;
  logic               count_en;
  logic               last_row;
  logic [BITSROW-1:0] row_idx;
  bank_req_t          bank_req [NUMVBNK];
  logic [PHYWDTH-1:0] bank_dout [NUMVBNK];
  rd_tag_t            rd_tag;
  rd_tag_t            rd_tag_dly;

  //########################################
  // clear after reset
  //########################################

  mem_init_fsm u_init_fsm (
    .clk         (clk),
    .rst         (rst),
    .last_row    (last_row),
    .init_active (init_active),
    .count_en    (count_en),
    .rw_ready    (rw_ready)
  );

  row_counter u_row_counter (
    .clk      (clk),
    .rst      (rst),
    .count_en (count_en),
    .row_idx  (row_idx),
    .last_row (last_row)
  );

  //########################################
  // command to banks
  //########################################

  bank_router u_bank_router (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .init_active (init_active),
    .row_idx     (row_idx),
    .bank_req    (bank_req),
    .rd_tag      (rd_tag)
  );

  for (genvar i = 0; i < NUMVBNK; i++) begin : gen_bank
    sram_bank u_sram_bank (
      .clk      (clk),
      .req      (bank_req[i]),
      .phy_dout (bank_dout[i])
    );
  end

  //########################################
  // read return path
  //########################################

  read_delay_timer u_read_delay (
    .clk     (clk),
    .rst     (rst),
    .tag_in  (rd_tag),
    .tag_out (rd_tag_dly)
  );

  read_return u_read_return (
    .clk       (clk),
    .rst       (rst),
    .tag       (rd_tag_dly),
    .bank_dout (bank_dout),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

/* verification/mem_1rw_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_1rw_tb;
  import mem_pkg::*;

  localparam int MAX_LINES     = 64;
  localparam int COLS          = 5;
  localparam int READY_TIMEOUT = 40;
  localparam int RSP_TIMEOUT   = 10;
  localparam int RSP_LATENCY   = 2;  // negedge that drives a read to the negedge that sees vld

  logic     clk;
  logic     rst;
  mem_cmd_t cmd;
  rd_rsp_t  rsp;
  logic     rw_ready;

  logic [15:0]      tdata [MAX_LINES*COLS];
  logic [WIDTH-1:0] model [NUMADDR];  // byte-merge reference of the memory contents
  int               err_count;
  int               test_count;
  int               fail_count;
  bit               timed_out;

  mem_1rw_top DUT (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .rsp      (rsp),
    .rw_ready (rw_ready)
  );

  always #50 clk = ~clk;

  //########################################
  // checks
  //########################################

  task automatic check_rsp(input rd_rsp_t got, input rd_rsp_t want, input string what);
    if (got !== want) begin
      $display("ERR %0t %s: got dout %04h perr %b, expected dout %04h perr %b",
               $time, what, got.dout, got.perr, want.dout, want.perr);
      err_count++;
    end
  endtask

  task automatic check_ready(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("ERR %0t %s: rw_ready is %b, expected %b", $time, what, got, want);
      err_count++;
    end
  endtask

  task automatic check_idle(input rd_rsp_t got, input string what);
    if (got.vld !== 1'b0) begin
      $display("ERR %0t %s: rsp.vld is %b, expected no response", $time, what, got.vld);
      err_count++;
    end
  endtask

  task automatic check_cycles(input int got, input int lo, input int hi, input string what);
    if (got < lo || got > hi) begin
      $display("ERR %0t %s: took %0d cycles, expected %0d to %0d", $time, what, got, lo, hi);
      err_count++;
    end
  endtask

  task automatic check_file_word(input logic [BITADDR-1:0] addr, input logic [WIDTH-1:0] word);
    if (model[addr] !== word) begin
      $display("ERR %0t data file expects %04h at address %02h, byte merge gives %04h",
               $time, word, addr, model[addr]);
      err_count++;
    end
  endtask

  //########################################
  // stimulus
  //########################################

  task automatic model_write(input logic [BITADDR-1:0] addr, input logic [NUMBYTE-1:0] bw,
                             input logic [WIDTH-1:0] data);
    for (int b = 0; b < NUMBYTE; b++) begin
      if (bw[b]) model[addr][b*BITBYTE +: BITBYTE] = data[b*BITBYTE +: BITBYTE];
    end
  endtask

  task automatic issue_write(input logic [BITADDR-1:0] addr, input logic [NUMBYTE-1:0] bw,
                             input logic [WIDTH-1:0] data);
    @(negedge clk);
    check_ready(rw_ready, 1'b1, "write issue");
    cmd           = '0;
    cmd.write     = 1'b1;
    cmd.addr.flat = addr;
    cmd.bw        = bw;
    cmd.din       = data;
    model_write(addr, bw, data);
  endtask

  // alternates writes to two addresses with a read while the memory is not ready
  task automatic drive_early(input int k);
    cmd           = '0;
    cmd.write     = (k % 2 == 1);
    cmd.read      = (k % 2 == 0);
    cmd.addr.flat = (k % 4 == 1) ? 5'h05 : 5'h09;
    cmd.bw        = '1;
    cmd.din       = 16'hbeef;
  endtask

  task automatic read_check(input logic [BITADDR-1:0] addr, input string what);
    rd_rsp_t want;
    bit      seen;
    int      waited;
    want      = '0;
    want.vld  = 1'b1;
    want.dout = model[addr];
    seen      = 0;
    waited    = 0;
    @(negedge clk);
    check_ready(rw_ready, 1'b1, what);
    cmd           = '0;
    cmd.read      = 1'b1;
    cmd.addr.flat = addr;
    while (!seen && waited < RSP_TIMEOUT) begin
      @(negedge clk);
      cmd = '0;
      waited++;
      if (rsp.vld) begin
        seen = 1;
        check_rsp(rsp, want, what);
        check_cycles(waited, RSP_LATENCY, RSP_LATENCY, what);
      end
    end
    if (!seen) begin
      $display("timeout: no read response within %0d cycles for %s", RSP_TIMEOUT, what);
      timed_out = 1;
      err_count++;
    end
  endtask

  task automatic burst(input logic [BITADDR-1:0] start, input int n, input string what);
    logic [BITADDR-1:0] addr_q [$];
    int                 issue_cyc [$];
    rd_rsp_t            want;
    logic [BITADDR-1:0] a;
    int                 cyc;
    int                 got;
    int                 issued;
    for (int i = 0; i < n; i++) begin
      issue_write(start + BITADDR'(i), '1, WIDTH'($urandom));
    end
    cyc    = 0;
    got    = 0;
    issued = 0;
    while (got < n && cyc < n + RSP_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (rsp.vld && got < issued) begin
        want      = '0;
        want.vld  = 1'b1;
        want.dout = model[addr_q[got]];
        check_rsp(rsp, want, $sformatf("%s read %0d", what, got));
        check_cycles(cyc - issue_cyc[got], RSP_LATENCY, RSP_LATENCY, what);
        got++;
      end
      cmd = '0;
      if (issued < n) begin
        a             = start + BITADDR'(issued);
        cmd.read      = 1'b1;
        cmd.addr.flat = a;
        addr_q.push_back(a);
        issue_cyc.push_back(cyc);
        issued++;
      end
    end
    cmd = '0;
    if (got < n) begin
      $display("timeout: only %0d of %0d burst responses arrived", got, n);
      timed_out = 1;
      err_count++;
    end
  endtask

  function automatic string op_name(input logic [15:0] op);
    case (op)
      16'h0:   return "write";
      16'h1:   return "read";
      16'h2:   return "write-read";
      16'h3:   return "burst";
      default: return "unknown";
    endcase
  endfunction

  //########################################
  // main sequence
  //########################################

  initial begin
    int                 low_cycles;
    int                 errs_before;
    bit                 ready;
    bit                 done;
    logic [15:0]        op;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
    logic [WIDTH-1:0]   expw;
    void'($urandom(32));
    clk        = 1'b0;
    rst        = 1'b1;
    cmd        = '0;
    err_count  = 0;
    test_count = 0;
    fail_count = 0;
    timed_out  = 0;
    for (int i = 0; i < NUMADDR; i++) model[i] = '0;
    for (int i = 0; i < MAX_LINES*COLS; i++) tdata[i] = 16'h000f;  // end marker everywhere
    $readmemh("verification/mem_testdata.txt", tdata);

    // commands during reset and the clear sweep must be ignored
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_ready(rw_ready, 1'b0, "reset");
      check_idle(rsp, "reset");
      drive_early(i);
    end
    rst        = 1'b0;
    low_cycles = 0;
    ready      = 0;
    for (int k = 0; k < READY_TIMEOUT && !ready; k++) begin
      @(negedge clk);
      if (rw_ready === 1'b1) begin
        ready = 1;
      end else begin
        low_cycles++;
        check_idle(rsp, "init");
        drive_early(k);
      end
    end
    cmd = '0;
    if (!ready) begin
      $display("timeout: rw_ready did not rise within %0d cycles of reset", READY_TIMEOUT);
      timed_out = 1;
      err_count++;
    end
    check_cycles(low_cycles, NUMSROW, NUMSROW, "clear sweep");
    test_count++;
    if (err_count != 0) fail_count++;
    $display("test %0d reset and init: %s", test_count, (err_count == 0) ? "pass" : "FAIL");

    done = 0;
    for (int ln = 0; ln < MAX_LINES && !done && !timed_out; ln++) begin
      op   = tdata[ln*COLS];
      addr = tdata[ln*COLS+1][BITADDR-1:0];
      data = tdata[ln*COLS+3];
      expw = tdata[ln*COLS+4];
      if (op == 16'h000f) begin
        done = 1;
      end else begin
        errs_before = err_count;
        case (op)
          16'h0: begin
            issue_write(addr, tdata[ln*COLS+2][NUMBYTE-1:0], data);
            @(negedge clk);
            cmd = '0;
          end
          16'h1: begin
            check_file_word(addr, expw);
            read_check(addr, $sformatf("read %02h", addr));
          end
          16'h2: begin
            issue_write(addr, tdata[ln*COLS+2][NUMBYTE-1:0], data);
            check_file_word(addr, expw);
            read_check(addr, $sformatf("read after write %02h", addr));
          end
          16'h3: burst(addr, int'(tdata[ln*COLS+2]), $sformatf("burst %02h", addr));
          default: begin
            $display("data file line %0d has an unknown operation code %0h", ln, op);
            err_count++;
          end
        endcase
        test_count++;
        if (err_count != errs_before) fail_count++;
        $display("test %0d %s addr %02h: %s", test_count, op_name(op), addr,
                 (err_count == errs_before) ? "pass" : "FAIL");
      end
    end

    $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/mem_testdata.txt */
// columns: op addr bw data expect, all hex
// op 0 write, 1 read, 2 write then read next cycle, 3 burst of bw words, f end
1 05 0 0000 0000
1 09 0 0000 0000
1 00 0 0000 0000
1 1f 0 0000 0000
0 00 3 1234 0000
0 01 3 5678 0000
0 02 3 9abc 0000
0 03 3 def0 0000
0 1c 3 a5a5 0000
1 00 0 0000 1234
1 01 0 0000 5678
1 02 0 0000 9abc
1 03 0 0000 def0
1 1c 0 0000 a5a5
0 00 1 00ff 0000
1 00 0 0000 12ff
0 00 2 cd00 0000
1 00 0 0000 cdff
0 1c 2 3c00 0000
1 1c 0 0000 3ca5
0 02 0 ffff 0000
1 02 0 0000 9abc
2 05 3 4321 4321
2 05 1 0077 4377
2 0e 2 8800 8800
3 10 8 0000 0000
3 1e 4 0000 0000
1 09 0 0000 0000
f 00 0 0000 0000

/* sources.f */
src/mem_pkg.sv
src/mem_init_fsm.sv
src/row_counter.sv
src/read_delay_timer.sv
src/bank_router.sv
src/sram_bank.sv
src/read_return.sv
src/mem_1rw_top.sv
verification/mem_1rw_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass message
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module mem_1rw_tb -f sources.f -o mem_1rw_sim; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/mem_1rw_sim)"
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
